// ==== common/gem_tx_pkg.sv ====
`default_nettype none

package gem_tx_pkg;

  // --------------------
  // Link geometry
  // --------------------

  // Transceiver lanes per link
  localparam int NUM_LINKS     = 4;
  // usrclk_160 frames in one bunch crossing
  localparam int FRAMES_PER_BX = 4;
  // Cluster bits carried by one lane per crossing
  localparam int CLUSTER_W     = 56;
  // Full cluster word, two lane halves
  localparam int GEM_DATA_W    = 2 * CLUSTER_W;
  // One transceiver lane word
  localparam int LANE_W        = 16;

  typedef logic [1:0] frame_phase_t;
  typedef logic [7:0] k_char_t;

  // --------------------
  // K-characters
  // --------------------

  // Flag separators, highest priority first
  localparam k_char_t K_BC0      = 8'h1C;
  localparam k_char_t K_RESYNC   = 8'h3C;
  localparam k_char_t K_OVERFLOW = 8'hFC;

  // Bunch sequence rotation, index 0 is sent first
  localparam k_char_t [3:0] K_SEQ = {8'hFD, 8'hFB, 8'hF7, 8'hBC};

  // Comma word sent while the link is down
  localparam logic [LANE_W-1:0] IDLE_WORD = 16'hFFFC;

  // K-flags per lane, one bit per byte
  localparam logic [1:0] ISK_SEP  = 2'b01;
  localparam logic [1:0] ISK_DATA = 2'b00;

  // Frame-0 word, seen raw or as separator plus first data byte
  typedef union packed {
    logic [LANE_W-1:0] raw;
    struct packed {
      k_char_t data;
      k_char_t sep;
    } bytes;
  } lane_word_u;

endpackage

`default_nettype wire

// ==== gem_framer/frame_sep_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sep_gen
  import gem_tx_pkg::*;
#(
  parameter int FRAME_CTRL_TTC = 1
) (
  input  wire logic       usrclk_160,
  input  wire logic       rst_i,
  input  wire logic       link_up_i,
  input  wire logic       bc0_i,
  input  wire logic       resync_i,
  input  wire logic       overflow_i,
  input  wire logic [1:0] bxn_lsbs_i,
  output k_char_t         sep_char_o
);

  // --------------------
  // Local sequence
  // --------------------

  // Runs in step with the frame phase, upper bits count crossings
  logic [3:0] seq_cnt;
  logic [1:0] seq_idx;

  always_ff @(posedge usrclk_160) begin
    if (rst_i || !link_up_i) begin
      seq_cnt <= '0;
    end else begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  // Rotation index from the timing counter or from the local count
  assign seq_idx = (FRAME_CTRL_TTC != 0) ? bxn_lsbs_i : seq_cnt[3:2];

  // --------------------
  // Separator choice
  // --------------------

  // Flags override the rotation, bc0 first
  always_comb begin
    if (bc0_i) begin
      sep_char_o = K_BC0;
    end else if (resync_i) begin
      sep_char_o = K_RESYNC;
    end else if (overflow_i) begin
      // More clusters than fit in the word
      sep_char_o = K_OVERFLOW;
    end else begin
      sep_char_o = K_SEQ[seq_idx];
    end
  end

endmodule

`default_nettype wire

// ==== gem_framer/link_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_framer
  import gem_tx_pkg::*;
(
  input  wire logic                  usrclk_160,
  input  wire logic                  rst_i,
  input  wire logic                  link_up_i,
  input  wire logic [GEM_DATA_W-1:0] gem_data_i,
  input  wire logic                  bc0_i,
  input  wire logic                  resync_i,
  input  wire logic                  overflow_i,
  input  wire logic [1:0]            bxn_lsbs_i,
  input  wire k_char_t               sep_char_i,
  output frame_phase_t               frame_phase_o,
  output logic                       bc0_o,
  output logic                       resync_o,
  output logic                       overflow_o,
  output logic [1:0]                 bxn_lsbs_o,
  output logic [NUM_LINKS-1:0][LANE_W-1:0] tx_data_o,
  output logic [NUM_LINKS-1:0][1:0]        tx_isk_o
);

  localparam frame_phase_t LAST_PHASE = frame_phase_t'(FRAMES_PER_BX - 1);

  logic [GEM_DATA_W-1:0] gem_data_q;
  logic [CLUSTER_W-1:0]  lane_half   [NUM_LINKS];
  lane_word_u            frame0_word [NUM_LINKS];

  // --------------------
  // Frame phase
  // --------------------

  always_ff @(posedge usrclk_160) begin
    frame_phase_o <= (rst_i || !link_up_i) ? '0 : frame_phase_o + 1'b1;
  end

  // Capture one crossing as the previous one finishes draining
  always_ff @(posedge usrclk_160) begin
    if (!link_up_i || (frame_phase_o == LAST_PHASE)) begin
      gem_data_q <= gem_data_i;
      bc0_o      <= bc0_i;
      resync_o   <= resync_i;
      overflow_o <= overflow_i;
      bxn_lsbs_o <= bxn_lsbs_i;
    end
  end

  // --------------------
  // Lane mapping
  // --------------------

  // Even lanes take the lower half, odd lanes the upper half
  always_comb begin
    for (int k = 0; k < NUM_LINKS; k++) begin
      lane_half[k] = (k % 2 != 0) ? gem_data_q[GEM_DATA_W-1:CLUSTER_W]
                                  : gem_data_q[CLUSTER_W-1:0];
      // Separator in the low byte, first data byte above it
      frame0_word[k].bytes.data = lane_half[k][7:0];
      frame0_word[k].bytes.sep  = sep_char_i;
    end
  end

  // Lane words and K-flags, idle commas while down
  always_ff @(posedge usrclk_160) begin
    for (int k = 0; k < NUM_LINKS; k++) begin
      if (rst_i || !link_up_i) begin
        tx_data_o[k] <= IDLE_WORD;
        tx_isk_o[k]  <= ISK_SEP;
      end else begin
        case (frame_phase_o)
          2'd0: begin
            tx_data_o[k] <= frame0_word[k].raw;
            tx_isk_o[k]  <= ISK_SEP;
          end
          2'd1: begin
            tx_data_o[k] <= lane_half[k][23:8];
            tx_isk_o[k]  <= ISK_DATA;
          end
          2'd2: begin
            tx_data_o[k] <= lane_half[k][39:24];
            tx_isk_o[k]  <= ISK_DATA;
          end
          default: begin
            tx_data_o[k] <= lane_half[k][55:40];
            tx_isk_o[k]  <= ISK_DATA;
          end
        endcase
      end
    end
  end

  // Separator flags on a running link only in frame 0
  a_sep_only_frame0 : assert property (
    @(posedge usrclk_160) disable iff (rst_i)
    ($past(link_up_i) && !$past(rst_i) && (tx_isk_o != {NUM_LINKS{ISK_DATA}}))
      |-> ($past(frame_phase_o) == '0)
  );

endmodule

`default_nettype wire

// ==== gem_link_tx.f ====
common/gem_tx_pkg.sv
hw/tx_startup_seq.sv
hw/link_ready_ctrl.sv
gem_framer/frame_sep_gen.sv
gem_framer/link_framer.sv
hw/gem_link_tx.sv
tests/gem_link_tx_checker.sv
tests/gem_link_tx_tb.sv

// ==== hw/gem_link_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_link_tx
  import gem_tx_pkg::*;
#(
  parameter int FRAME_CTRL_TTC      = 1,
  parameter int STARTUP_UNIT_CYCLES = 320000,
  parameter int READY_HOLD_CYCLES   = 1048576
) (
  input  wire logic                  usrclk_160,
  input  wire logic                  rst_i,
  input  wire logic [GEM_DATA_W-1:0] gem_data_i,
  input  wire logic                  overflow_i,
  input  wire logic                  bc0_i,
  input  wire logic                  resync_i,
  input  wire logic [1:0]            bxn_lsbs_i,
  input  wire logic                  tx_up_i,
  input  wire logic                  force_not_ready_i,
  input  wire logic [NUM_LINKS-1:0]  mgt_reset_i,
  input  wire logic                  tx_reset_i,
  output logic [NUM_LINKS-1:0][LANE_W-1:0] tx_data_o,
  output logic [NUM_LINKS-1:0][1:0]        tx_isk_o,
  output logic [NUM_LINKS-1:0]       mgt_reset_o,
  output logic                       tx_reset_o,
  output logic                       startup_done_o,
  output logic                       ready_o
);

  logic         link_up;
  logic         bc0_q;
  logic         resync_q;
  logic         overflow_q;
  logic [1:0]   bxn_lsbs_q;
  k_char_t      sep_char;

  // --------------------
  // Side control
  // --------------------

  tx_startup_seq #(
    .STARTUP_UNIT_CYCLES(STARTUP_UNIT_CYCLES)
  ) tx_startup_seq_i (
    .usrclk_160    (usrclk_160),
    .rst_i         (rst_i),
    .mgt_reset_i   (mgt_reset_i),
    .tx_reset_i    (tx_reset_i),
    .mgt_reset_o   (mgt_reset_o),
    .tx_reset_o    (tx_reset_o),
    .startup_done_o(startup_done_o)
  );

  link_ready_ctrl #(
    .READY_HOLD_CYCLES(READY_HOLD_CYCLES)
  ) link_ready_ctrl_i (
    .usrclk_160       (usrclk_160),
    .rst_i            (rst_i),
    .tx_up_i          (tx_up_i),
    .force_not_ready_i(force_not_ready_i),
    .link_up_o        (link_up),
    .ready_o          (ready_o)
  );

  // --------------------
  // Datapath
  // --------------------

  // Frame phase stays inside the framer, the separator keeps its own count
  link_framer link_framer_i (
    .usrclk_160   (usrclk_160),
    .rst_i        (rst_i),
    .link_up_i    (link_up),
    .gem_data_i   (gem_data_i),
    .bc0_i        (bc0_i),
    .resync_i     (resync_i),
    .overflow_i   (overflow_i),
    .bxn_lsbs_i   (bxn_lsbs_i),
    .sep_char_i   (sep_char),
    .frame_phase_o(),
    .bc0_o        (bc0_q),
    .resync_o     (resync_q),
    .overflow_o   (overflow_q),
    .bxn_lsbs_o   (bxn_lsbs_q),
    .tx_data_o    (tx_data_o),
    .tx_isk_o     (tx_isk_o)
  );

  // Separator works on the captured crossing
  frame_sep_gen #(
    .FRAME_CTRL_TTC(FRAME_CTRL_TTC)
  ) frame_sep_gen_i (
    .usrclk_160(usrclk_160),
    .rst_i     (rst_i),
    .link_up_i (link_up),
    .bc0_i     (bc0_q),
    .resync_i  (resync_q),
    .overflow_i(overflow_q),
    .bxn_lsbs_i(bxn_lsbs_q),
    .sep_char_o(sep_char)
  );

endmodule

`default_nettype wire

// ==== hw/link_ready_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_ready_ctrl #(
  parameter int READY_HOLD_CYCLES = 1048576
) (
  input  wire logic usrclk_160,
  input  wire logic rst_i,
  input  wire logic tx_up_i,
  input  wire logic force_not_ready_i,
  output logic      link_up_o,
  output logic      ready_o
);

  localparam int HOLD_W = $clog2(READY_HOLD_CYCLES + 1);

  logic [HOLD_W-1:0] hold_cnt;

  // Transceiver up status, one cycle behind the input
  always_ff @(posedge usrclk_160) begin
    link_up_o <= rst_i ? 1'b0 : tx_up_i;
  end

  // Hold timer, restarts whenever the link drops or is forced down
  always_ff @(posedge usrclk_160) begin
    if (rst_i || !link_up_o || force_not_ready_i) begin
      hold_cnt <= '0;
    end else if (hold_cnt != HOLD_W'(READY_HOLD_CYCLES)) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Ready after the full hold; drops with link-up or force
  assign ready_o = (hold_cnt == HOLD_W'(READY_HOLD_CYCLES)) &&
                   link_up_o && !force_not_ready_i;

endmodule

`default_nettype wire

// ==== hw/tx_startup_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_startup_seq
  import gem_tx_pkg::*;
#(
  parameter int STARTUP_UNIT_CYCLES = 320000
) (
  input  wire logic                 usrclk_160,
  input  wire logic                 rst_i,
  input  wire logic [NUM_LINKS-1:0] mgt_reset_i,
  input  wire logic                 tx_reset_i,
  output logic      [NUM_LINKS-1:0] mgt_reset_o,
  output logic                      tx_reset_o,
  output logic                      startup_done_o
);

  // --------------------
  // Thresholds
  // --------------------

  // Lane reset release points in units, staggered per lane
  localparam int MGT_RST_UNITS [NUM_LINKS] = '{2, 4, 6, 7};
  // Datapath reset pulse position
  localparam int TX_RST_CNT = 9 * STARTUP_UNIT_CYCLES;
  // Startup done once the count passes this
  localparam int DONE_CNT   = 15 * STARTUP_UNIT_CYCLES;
  // Counter parks one above done
  localparam int CNT_MAX    = DONE_CNT + 1;
  localparam int CNT_W      = $clog2(CNT_MAX + 1);

  logic [CNT_W-1:0] startup_cnt;
  logic             tx_rst_pulse;

  // Saturating startup counter, restarts on reset
  always_ff @(posedge usrclk_160) begin
    if (rst_i) begin
      startup_cnt <= '0;
    end else if (startup_cnt != CNT_W'(CNT_MAX)) begin
      startup_cnt <= startup_cnt + 1'b1;
    end
  end

  // Lane k held in reset below its threshold or on manual request
  for (genvar k = 0; k < NUM_LINKS; k++) begin : g_lane_rst
    assign mgt_reset_o[k] = mgt_reset_i[k] ||
                            (startup_cnt < CNT_W'(MGT_RST_UNITS[k] * STARTUP_UNIT_CYCLES));
  end

  // Single-cycle datapath reset after all lanes are released
  assign tx_rst_pulse   = (startup_cnt == CNT_W'(TX_RST_CNT));
  assign tx_reset_o     = tx_reset_i || tx_rst_pulse;

  assign startup_done_o = (startup_cnt > CNT_W'(DONE_CNT));

  // --------------------
  // Checks
  // --------------------

  // Counter-driven datapath reset never stretches
  a_tx_rst_one_cycle : assert property (
    @(posedge usrclk_160) disable iff (rst_i)
    tx_rst_pulse |=> !tx_rst_pulse
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench for both separator modes with Verilator
cd "$(dirname "$0")" || exit 1

for ttc in 1 0; do
  log="sim_ttc${ttc}.log"
  rm -rf "obj_ttc${ttc}" "$log"
  verilator --binary --timing --assert -j 0 --top-module gem_link_tx_tb \
    -GFRAME_CTRL_TTC="$ttc" --Mdir "obj_ttc${ttc}" -f gem_link_tx.f \
    && "./obj_ttc${ttc}/Vgem_link_tx_tb" > "$log" 2>&1 \
    || { echo "FRAME_CTRL_TTC=$ttc: build or run failed"; cat "$log" 2>/dev/null; exit 1; }
  cat "$log"
  grep -q "Done: errors found" "$log" && { echo "FRAME_CTRL_TTC=$ttc: FAILED"; exit 1; }
  grep -q "Done: no errors" "$log" || { echo "FRAME_CTRL_TTC=$ttc: no result"; exit 1; }
  echo "FRAME_CTRL_TTC=$ttc: passed"
done
exit 0

// ==== tests/gem_link_tx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_link_tx_checker
  import gem_tx_pkg::*;
#(
  parameter int FRAME_CTRL_TTC      = 1,
  parameter int STARTUP_UNIT_CYCLES = 4,
  parameter int READY_HOLD_CYCLES   = 16
) (
  input  wire logic                          usrclk_160,
  input  wire logic                          rst_i,
  input  wire logic [GEM_DATA_W-1:0]         gem_data_i,
  input  wire logic                          overflow_i,
  input  wire logic                          bc0_i,
  input  wire logic                          resync_i,
  input  wire logic [1:0]                    bxn_lsbs_i,
  input  wire logic                          tx_up_i,
  input  wire logic                          force_not_ready_i,
  input  wire logic [NUM_LINKS-1:0]          mgt_reset_i,
  input  wire logic                          tx_reset_i,
  input  wire logic [NUM_LINKS*LANE_W-1:0]   tx_data_i,
  input  wire logic [2*NUM_LINKS-1:0]        tx_isk_i,
  input  wire logic [NUM_LINKS-1:0]          mgt_reset_dut_i,
  input  wire logic                          tx_reset_dut_i,
  input  wire logic                          startup_done_i,
  input  wire logic                          ready_i,
  input  wire logic [2:0]                    test_id_i,
  output int                                 err_cnt_o,
  output int                                 check_cnt_o
);

  localparam int U = STARTUP_UNIT_CYCLES;

  // Model state, valid after the first reset edge
  logic                  model_ok = 1'b0;
  logic                  link_up_m;
  logic [1:0]            phase_m;
  logic [1:0]            bx_idx_m;
  logic [GEM_DATA_W-1:0] cap_data;
  logic                  cap_bc0;
  logic                  cap_resync;
  logic                  cap_ovf;
  logic [1:0]            cap_bxn;
  logic [NUM_LINKS*LANE_W-1:0] exp_data;
  logic [2*NUM_LINKS-1:0]      exp_isk;
  int                    start_cnt = 0;
  int                    hold_cnt = 0;

  // Bookkeeping
  logic [2:0] cur_test = 3'd0;
  int         test_checks = 0;
  int         test_errs = 0;
  int         check_total = 0;
  int         err_total = 0;

  assign err_cnt_o   = err_total;
  assign check_cnt_o = check_total;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset_idle";
      3'd1:    return "startup_first";
      3'd2:    return "link_ready";
      3'd3:    return "random_traffic";
      3'd4:    return "startup_second";
      3'd5:    return "traffic_after_reset";
      default: return "end_of_run";
    endcase
  endfunction

  // Separator priority, then the bunch rotation BC F7 FB FD
  function automatic logic [7:0] pick_sep(input logic bc0, input logic resync,
                                          input logic ovf, input logic [1:0] idx);
    if (bc0) return 8'h1C;
    if (resync) return 8'h3C;
    if (ovf) return 8'hFC;
    case (idx)
      2'd0:    return 8'hBC;
      2'd1:    return 8'hF7;
      2'd2:    return 8'hFB;
      default: return 8'hFD;
    endcase
  endfunction

  // Lane word per frame, low data bits go first
  function automatic logic [15:0] frame_word(input logic [55:0] half, input logic [1:0] ph,
                                             input logic [7:0] sep);
    case (ph)
      2'd0:    return {half[7:0], sep};
      2'd1:    return half[23:8];
      2'd2:    return half[39:24];
      default: return half[55:40];
    endcase
  endfunction

  // Lane k leaves reset at 2, 4, 6 and 7 units
  function automatic int lane_units(input int k);
    case (k)
      0:       return 2;
      1:       return 4;
      2:       return 6;
      default: return 7;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    check_total++;
    test_checks++;
    if (act_v !== exp_v) begin
      err_total++;
      test_errs++;
      $display("[FAIL] %0s %0s: expected %h, actual %h",
               test_name(cur_test), what, exp_v, act_v);
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  always @(posedge usrclk_160) begin
    logic [7:0]  sep;
    logic [55:0] half;
    sep = pick_sep(cap_bc0, cap_resync, cap_ovf,
                   (FRAME_CTRL_TTC != 0) ? cap_bxn : bx_idx_m);
    for (int k = 0; k < NUM_LINKS; k++) begin
      // Odd lanes carry the upper half
      half = (k % 2 != 0) ? cap_data[111:56] : cap_data[55:0];
      if (rst_i || !link_up_m) begin
        exp_data[k*16 +: 16] <= 16'hFFFC;
        exp_isk[k*2 +: 2]    <= 2'b01;
      end else begin
        exp_data[k*16 +: 16] <= frame_word(half, phase_m, sep);
        exp_isk[k*2 +: 2]    <= (phase_m == 2'd0) ? 2'b01 : 2'b00;
      end
    end
    // New crossing taken while down or on the last frame
    if (!link_up_m || phase_m == 2'd3) begin
      cap_data   <= gem_data_i;
      cap_bc0    <= bc0_i;
      cap_resync <= resync_i;
      cap_ovf    <= overflow_i;
      cap_bxn    <= bxn_lsbs_i;
    end
    phase_m <= (rst_i || !link_up_m) ? 2'd0 : phase_m + 2'd1;
    if (rst_i || !link_up_m) begin
      bx_idx_m <= 2'd0;
    end else if (phase_m == 2'd3) begin
      bx_idx_m <= bx_idx_m + 2'd1;
    end
    link_up_m <= rst_i ? 1'b0 : tx_up_i;
    // Startup count and ready hold timer, both saturating
    start_cnt <= rst_i ? 0 : ((start_cnt < 16 * U) ? start_cnt + 1 : start_cnt);
    if (rst_i || !link_up_m || force_not_ready_i) begin
      hold_cnt <= 0;
    end else if (hold_cnt < READY_HOLD_CYCLES) begin
      hold_cnt <= hold_cnt + 1;
    end
    if (rst_i) begin
      model_ok <= 1'b1;
    end
  end

  // --------------------
  // Comparison
  // --------------------

  // Outputs are settled at the falling edge
  always @(negedge usrclk_160) begin : compare_outputs
    logic [NUM_LINKS-1:0] exp_mgt;
    logic                 exp_txr;
    logic                 exp_done;
    logic                 exp_rdy;
    if (test_id_i != cur_test) begin
      $display("Test %0s: %0d checks, %0d errors", test_name(cur_test), test_checks, test_errs);
      cur_test    = test_id_i;
      test_checks = 0;
      test_errs   = 0;
    end
    if (model_ok) begin
      for (int k = 0; k < NUM_LINKS; k++) begin
        exp_mgt[k] = mgt_reset_i[k] || (start_cnt < lane_units(k) * U);
      end
      exp_txr  = tx_reset_i || (start_cnt == 9 * U);
      exp_done = (start_cnt > 15 * U);
      // Drops at once on force, one cycle after a tx_up_i drop
      exp_rdy  = (hold_cnt == READY_HOLD_CYCLES) && link_up_m && !force_not_ready_i;
      check_value("lane data", exp_data, tx_data_i);
      check_value("lane isk", 64'(exp_isk), 64'(tx_isk_i));
      check_value("mgt_reset", 64'(exp_mgt), 64'(mgt_reset_dut_i));
      check_value("tx_reset", 64'(exp_txr), 64'(tx_reset_dut_i));
      check_value("startup_done", 64'(exp_done), 64'(startup_done_i));
      check_value("ready", 64'(exp_rdy), 64'(ready_i));
    end
  end

endmodule

`default_nettype wire

// ==== tests/gem_link_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_link_tx_tb
  import gem_tx_pkg::*;
#(
  parameter int FRAME_CTRL_TTC = 1
);

  localparam int UNIT       = 4;
  localparam int HOLD       = 16;
  localparam int RST_CYCLES = 5;
  localparam int TRAFFIC_A  = 600;
  localparam int TRAFFIC_B  = 300;
  // Startup, link-up and ready wait twice, both traffic runs, then margin
  localparam int STARTUP_CYCLES = 16 * UNIT + 4;
  localparam int TIMEOUT_CYCLES = 2 * (RST_CYCLES + STARTUP_CYCLES + HOLD + 4) +
                                  TRAFFIC_A + TRAFFIC_B + 200;

  logic                    usrclk_160 = 1'b0;
  logic                    rst_i;
  logic [GEM_DATA_W-1:0]   gem_data_i;
  logic                    overflow_i;
  logic                    bc0_i;
  logic                    resync_i;
  logic [1:0]              bxn_lsbs_i;
  logic                    tx_up_i;
  logic                    force_not_ready_i;
  logic [NUM_LINKS-1:0]    mgt_reset_i;
  logic                    tx_reset_i;
  logic [NUM_LINKS-1:0][LANE_W-1:0] tx_data_o;
  logic [NUM_LINKS-1:0][1:0]        tx_isk_o;
  logic [NUM_LINKS-1:0]    mgt_reset_o;
  logic                    tx_reset_o;
  logic                    startup_done_o;
  logic                    ready_o;

  integer     seed = 32'ha8af_5d40;
  int         cycle_cnt = 0;
  logic [2:0] test_id;
  int         err_cnt;
  int         check_cnt;

  initial begin
    forever #20 usrclk_160 = ~usrclk_160;
  end

  gem_link_tx #(
    .FRAME_CTRL_TTC     (FRAME_CTRL_TTC),
    .STARTUP_UNIT_CYCLES(UNIT),
    .READY_HOLD_CYCLES  (HOLD)
  ) gem_link_tx_i (
    .usrclk_160       (usrclk_160),
    .rst_i            (rst_i),
    .gem_data_i       (gem_data_i),
    .overflow_i       (overflow_i),
    .bc0_i            (bc0_i),
    .resync_i         (resync_i),
    .bxn_lsbs_i       (bxn_lsbs_i),
    .tx_up_i          (tx_up_i),
    .force_not_ready_i(force_not_ready_i),
    .mgt_reset_i      (mgt_reset_i),
    .tx_reset_i       (tx_reset_i),
    .tx_data_o        (tx_data_o),
    .tx_isk_o         (tx_isk_o),
    .mgt_reset_o      (mgt_reset_o),
    .tx_reset_o       (tx_reset_o),
    .startup_done_o   (startup_done_o),
    .ready_o          (ready_o)
  );

  gem_link_tx_checker #(
    .FRAME_CTRL_TTC     (FRAME_CTRL_TTC),
    .STARTUP_UNIT_CYCLES(UNIT),
    .READY_HOLD_CYCLES  (HOLD)
  ) chk_i (
    .usrclk_160       (usrclk_160),
    .rst_i            (rst_i),
    .gem_data_i       (gem_data_i),
    .overflow_i       (overflow_i),
    .bc0_i            (bc0_i),
    .resync_i         (resync_i),
    .bxn_lsbs_i       (bxn_lsbs_i),
    .tx_up_i          (tx_up_i),
    .force_not_ready_i(force_not_ready_i),
    .mgt_reset_i      (mgt_reset_i),
    .tx_reset_i       (tx_reset_i),
    .tx_data_i        (tx_data_o),
    .tx_isk_i         (tx_isk_o),
    .mgt_reset_dut_i  (mgt_reset_o),
    .tx_reset_dut_i   (tx_reset_o),
    .startup_done_i   (startup_done_o),
    .ready_i          (ready_o),
    .test_id_i        (test_id),
    .err_cnt_o        (err_cnt),
    .check_cnt_o      (check_cnt)
  );

  // Reset pulse with the link down and no manual requests
  task automatic reset_dut();
    rst_i             <= 1'b1;
    tx_up_i           <= 1'b0;
    force_not_ready_i <= 1'b0;
    mgt_reset_i       <= '0;
    tx_reset_i        <= 1'b0;
    repeat (RST_CYCLES) @(posedge usrclk_160);
    rst_i <= 1'b0;
  endtask

  task automatic wait_startup_done();
    @(posedge usrclk_160);
    while (!startup_done_o) @(posedge usrclk_160);
  endtask

  task automatic wait_ready();
    @(posedge usrclk_160);
    while (!ready_o) @(posedge usrclk_160);
  endtask

  // Random crossings, rare flags, link drops, force pulses and manual resets
  task automatic drive_random_traffic(input int cycles);
    int           r;
    int           r2;
    logic         flag_evt;
    logic [127:0] rnd;
    repeat (cycles) begin
      @(posedge usrclk_160);
      r   = $random(seed);
      r2  = $random(seed);
      rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
      // Rare flag event, flags inside it often coincide
      flag_evt = (r[2:0] == 3'd0);
      gem_data_i        <= rnd[GEM_DATA_W-1:0];
      bc0_i             <= flag_evt && r[3];
      resync_i          <= flag_evt && r[4];
      overflow_i        <= flag_evt && r[5];
      bxn_lsbs_i        <= r[16:15];
      tx_up_i           <= (r[23:17] != 7'd0);
      force_not_ready_i <= (r[29:24] == 6'd0);
      mgt_reset_i       <= (r2[5:0] == 6'd0) ? r2[9:6] : 4'd0;
      tx_reset_i        <= (r2[15:10] == 6'd0);
    end
  endtask

  // Run limit
  always @(posedge usrclk_160) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    rst_i             = 1'b1;
    gem_data_i        = '0;
    overflow_i        = 1'b0;
    bc0_i             = 1'b0;
    resync_i          = 1'b0;
    bxn_lsbs_i        = 2'd0;
    tx_up_i           = 1'b0;
    force_not_ready_i = 1'b0;
    mgt_reset_i       = '0;
    tx_reset_i        = 1'b0;
    test_id           = 3'd0;
    repeat (RST_CYCLES) @(posedge usrclk_160);
    rst_i   <= 1'b0;
    test_id <= 3'd1;
    wait_startup_done();
    test_id <= 3'd2;
    tx_up_i <= 1'b1;
    wait_ready();
    test_id <= 3'd3;
    drive_random_traffic(TRAFFIC_A);
    // Second startup from a fresh reset
    test_id <= 3'd4;
    reset_dut();
    wait_startup_done();
    tx_up_i <= 1'b1;
    wait_ready();
    test_id <= 3'd5;
    drive_random_traffic(TRAFFIC_B);
    test_id <= 3'd6;
    repeat (2) @(posedge usrclk_160);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
